// ==== src/ipic_pkg.sv ====
/*
 * Shared widths, types and register map of the interrupt controller.
 * Referenced by scoped name from every RTL block.
 */

`default_nettype none

package ipic_pkg;

    //------------------------------------------------------------
    // Widths
    //------------------------------------------------------------
    localparam int IRQ_NUM    = 16;              // Interrupt lines
    localparam int LINE_W     = $clog2(IRQ_NUM); // Line number width
    localparam int VECT_W     = LINE_W + 1;      // Line number plus void
    localparam int CSR_ADDR_W = 3;
    localparam int CSR_DATA_W = 32;

    typedef logic [IRQ_NUM-1:0]    irq_vec_t;   // One bit per line
    typedef logic [LINE_W-1:0]     line_idx_t;
    typedef logic [VECT_W-1:0]     vect_num_t;  // 16 means void
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    localparam vect_num_t VOID_VECT = vect_num_t'(IRQ_NUM); // Nothing in service

    //------------------------------------------------------------
    // Register map, address 1 unused
    //------------------------------------------------------------
    localparam csr_addr_t ADDR_CISV = 3'd0;
    localparam csr_addr_t ADDR_IPR  = 3'd2;
    localparam csr_addr_t ADDR_ISVR = 3'd3;
    localparam csr_addr_t ADDR_EOI  = 3'd4;
    localparam csr_addr_t ADDR_SOI  = 3'd5;
    localparam csr_addr_t ADDR_IDX  = 3'd6;
    localparam csr_addr_t ADDR_ICSR = 3'd7;

    // ICSR fields
    localparam int ICSR_IP     = 0;  // Pending, write 1 to clear
    localparam int ICSR_IE     = 1;  // Enable
    localparam int ICSR_IM     = 2;  // Mode, 1 = edge
    localparam int ICSR_INV    = 3;  // Line inversion
    localparam int ICSR_IS     = 4;  // In service, read only
    localparam int ICSR_LN_LSB = 12; // Line number field

    // Register port request, one cycle per access
    typedef struct packed {
        logic      rd;
        logic      wr;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_req_t;

    // Line mode and inversion as seen after this cycle's write
    typedef struct packed {
        irq_vec_t im;
        irq_vec_t inv;
    } line_cfg_t;

endpackage

`default_nettype wire

// ==== src/ipic_line_detect.sv ====
/*
 * Per-line level/edge detection and the pending register.
 * Lines are taken as synchronous to clk.
 */

`timescale 1ns/1ps
`default_nettype none

module ipic_line_detect (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire ipic_pkg::irq_vec_t  irq_lines,
    input  wire ipic_pkg::line_cfg_t line_cfg,
    input  wire ipic_pkg::irq_vec_t  sw_clr,   // Software clear
    input  wire ipic_pkg::irq_vec_t  soi_clr,  // Clear of accepted line
    output ipic_pkg::irq_vec_t       ipr
);

    ipic_pkg::irq_vec_t irq_prev;  // Previous sample for edge detect
    ipic_pkg::irq_vec_t irq_lvl;   // Active level after inversion
    ipic_pkg::irq_vec_t irq_edge;  // Change toward active
    ipic_pkg::irq_vec_t clr;
    ipic_pkg::irq_vec_t ipr_nxt;

    assign irq_lvl  = irq_lines ^ line_cfg.inv;
    assign irq_edge = (irq_prev ^ irq_lines) & irq_lvl;
    assign clr      = sw_clr | soi_clr;

    //------------------------------------------------------------
    // Pending update
    //------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < ipic_pkg::IRQ_NUM; i++) begin
            if (clr[i] && (!irq_lvl[i] || line_cfg.im[i])) begin
                ipr_nxt[i] = 1'b0;                    // Clear honoured
            end else if (line_cfg.im[i]) begin
                ipr_nxt[i] = ipr[i] | irq_edge[i];    // Edge, sticky
            end else begin
                ipr_nxt[i] = irq_lvl[i];              // Level, follows line
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_prev <= '0;
            ipr      <= '0;
        end else begin
            irq_prev <= irq_lines;
            ipr      <= ipr_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== src/ipic_prio_search.sv ====
/*
 * Lowest-set-bit search over a 16-bit line vector.
 * Pure combinational tree, no clock.
 */

`timescale 1ns/1ps
`default_nettype none

module ipic_prio_search (
    input  wire ipic_pkg::irq_vec_t vec,
    output logic                    found,
    output ipic_pkg::line_idx_t     idx
);

    logic [7:0]      vd1;  // Leaf pairs
    logic [7:0]      ix1;
    logic [3:0]      vd2;  // Groups of 4
    logic [3:0][1:0] ix2;
    logic [1:0]      vd3;  // Groups of 8
    logic [1:0][2:0] ix3;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            vd1[i] = vec[2*i] | vec[2*i+1];
            ix1[i] = ~vec[2*i];                  // Even bit wins
        end
        for (int i = 0; i < 4; i++) begin
            vd2[i] = vd1[2*i] | vd1[2*i+1];
            ix2[i] = vd1[2*i] ? {1'b0, ix1[2*i]} : {1'b1, ix1[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            vd3[i] = vd2[2*i] | vd2[2*i+1];
            ix3[i] = vd2[2*i] ? {1'b0, ix2[2*i]} : {1'b1, ix2[2*i+1]};
        end
    end

    // Root merge, lower half first
    assign found = vd3[0] | vd3[1];
    assign idx   = vd3[0] ? {1'b0, ix3[0]} : {1'b1, ix3[1]};

endmodule

`default_nettype wire

// ==== src/ipic_service.sv ====
/*
 * In-service tracking and request generation.
 * SOI pushes the winning line, EOI pops the current one.
 */

`timescale 1ns/1ps
`default_nettype none

module ipic_service (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ipic_pkg::irq_vec_t ipr,
    input  wire ipic_pkg::irq_vec_t ier,
    input  wire logic               soi_wr,
    input  wire logic               eoi_wr,
    output logic                    irq_req,
    output ipic_pkg::irq_vec_t      soi_clr,
    output ipic_pkg::irq_vec_t      isvr,
    output ipic_pkg::vect_num_t     cisv
);

    ipic_pkg::irq_vec_t  irr;        // Pending and enabled
    ipic_pkg::irq_vec_t  isvr_eoi;   // In service minus current
    logic                req_found;
    ipic_pkg::line_idx_t req_idx;
    logic                nxt_found;
    ipic_pkg::line_idx_t nxt_idx;
    logic                soi_acc;
    logic                eoi_acc;

    assign irr = ipr & ier;

    ipic_prio_search u_req_search (.vec(irr),      .found(req_found), .idx(req_idx));
    ipic_prio_search u_eoi_search (.vec(isvr_eoi), .found(nxt_found), .idx(nxt_idx));

    always_comb begin
        isvr_eoi = isvr;
        for (int i = 0; i < ipic_pkg::IRQ_NUM; i++) begin
            if (cisv == ipic_pkg::vect_num_t'(i)) begin
                isvr_eoi[i] = 1'b0;
            end
        end
    end

    // Idle, or winner preempts current
    assign irq_req = req_found && ((isvr == '0) || (ipic_pkg::vect_num_t'(req_idx) < cisv));
    assign soi_acc = soi_wr & irq_req;
    assign eoi_acc = eoi_wr & (cisv != ipic_pkg::VOID_VECT);

    always_comb begin
        soi_clr = '0;
        if (soi_acc) soi_clr[req_idx] = 1'b1;  // One-hot on accept only
    end

    //------------------------------------------------------------
    // Service state
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr <= '0;
            cisv <= ipic_pkg::VOID_VECT;
        end else if (soi_acc) begin
            isvr <= isvr | soi_clr;
            cisv <= ipic_pkg::vect_num_t'(req_idx);
        end else if (eoi_acc) begin
            isvr <= isvr_eoi;
            cisv <= nxt_found ? ipic_pkg::vect_num_t'(nxt_idx) : ipic_pkg::VOID_VECT;
        end
    end

endmodule

`default_nettype wire

// ==== src/ipic_csr.sv ====
/*
 * Register block: enable, mode, inversion and index registers,
 * read multiplexer and write decode into clear and SOI/EOI strobes.
 */

`timescale 1ns/1ps
`default_nettype none

module ipic_csr (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire ipic_pkg::csr_req_t  csr_req,
    input  wire ipic_pkg::irq_vec_t  ipr,
    input  wire ipic_pkg::irq_vec_t  isvr,
    input  wire ipic_pkg::vect_num_t cisv,
    output ipic_pkg::csr_data_t      csr_rdata,
    output ipic_pkg::line_cfg_t      line_cfg,  // Next mode and inversion
    output ipic_pkg::irq_vec_t       ier,
    output ipic_pkg::irq_vec_t       sw_clr,
    output logic                     soi_wr,
    output logic                     eoi_wr
);

    ipic_pkg::irq_vec_t  imr;       // Mode, 1 = edge
    ipic_pkg::irq_vec_t  invr;      // Inversion
    ipic_pkg::line_idx_t idx;       // ICSR line select
    ipic_pkg::irq_vec_t  ier_nxt;
    logic                wr_icsr;
    logic                wr_ipr;
    logic                wr_idx;

    // Write decode
    assign wr_icsr = csr_req.wr && (csr_req.addr == ipic_pkg::ADDR_ICSR);
    assign wr_ipr  = csr_req.wr && (csr_req.addr == ipic_pkg::ADDR_IPR);
    assign wr_idx  = csr_req.wr && (csr_req.addr == ipic_pkg::ADDR_IDX);
    assign soi_wr  = csr_req.wr && (csr_req.addr == ipic_pkg::ADDR_SOI);
    assign eoi_wr  = csr_req.wr && (csr_req.addr == ipic_pkg::ADDR_EOI);

    //------------------------------------------------------------
    // Next values of the per-line control bits
    //------------------------------------------------------------
    always_comb begin
        ier_nxt      = ier;
        line_cfg.im  = imr;
        line_cfg.inv = invr;
        if (wr_icsr) begin
            ier_nxt[idx]      = csr_req.wdata[ipic_pkg::ICSR_IE];
            line_cfg.im[idx]  = csr_req.wdata[ipic_pkg::ICSR_IM];
            line_cfg.inv[idx] = csr_req.wdata[ipic_pkg::ICSR_INV];
        end
    end

    // Pending clears, IPR is write-1-to-clear
    always_comb begin
        sw_clr = '0;
        if (wr_ipr) begin
            sw_clr = csr_req.wdata[ipic_pkg::IRQ_NUM-1:0];
        end else if (wr_icsr) begin
            sw_clr[idx] = csr_req.wdata[ipic_pkg::ICSR_IP];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ier  <= '0;
            imr  <= '0;
            invr <= '0;
            idx  <= '0;
        end else begin
            ier  <= ier_nxt;
            imr  <= line_cfg.im;
            invr <= line_cfg.inv;
            if (wr_idx) idx <= csr_req.wdata[ipic_pkg::LINE_W-1:0];
        end
    end

    //------------------------------------------------------------
    // Read mux, zero when idle
    //------------------------------------------------------------
    always_comb begin
        csr_rdata = '0;
        if (csr_req.rd) begin
            case (csr_req.addr)
                ipic_pkg::ADDR_CISV: csr_rdata = ipic_pkg::csr_data_t'(cisv);
                ipic_pkg::ADDR_IPR:  csr_rdata = ipic_pkg::csr_data_t'(ipr);
                ipic_pkg::ADDR_ISVR: csr_rdata = ipic_pkg::csr_data_t'(isvr);
                ipic_pkg::ADDR_IDX:  csr_rdata = ipic_pkg::csr_data_t'(idx);
                ipic_pkg::ADDR_ICSR: begin
                    csr_rdata[ipic_pkg::ICSR_IP]  = ipr[idx];
                    csr_rdata[ipic_pkg::ICSR_IE]  = ier[idx];
                    csr_rdata[ipic_pkg::ICSR_IM]  = imr[idx];
                    csr_rdata[ipic_pkg::ICSR_INV] = invr[idx];
                    csr_rdata[ipic_pkg::ICSR_IS]  = isvr[idx];
                    csr_rdata[ipic_pkg::ICSR_LN_LSB +: ipic_pkg::LINE_W] = idx;
                end
                default: csr_rdata = '0;  // EOI, SOI, unused
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/ipic_top.sv ====
/*
 * Interrupt controller top level.
 * Connects line detection, service tracking and the register block.
 */

`timescale 1ns/1ps
`default_nettype none

module ipic_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ipic_pkg::irq_vec_t irq_lines,
    input  wire ipic_pkg::csr_req_t csr_req,
    output ipic_pkg::csr_data_t     csr_rdata,
    output logic                    irq_req
);

    ipic_pkg::line_cfg_t line_cfg;
    ipic_pkg::irq_vec_t  sw_clr;
    ipic_pkg::irq_vec_t  soi_clr;
    ipic_pkg::irq_vec_t  ipr;
    ipic_pkg::irq_vec_t  ier;
    ipic_pkg::irq_vec_t  isvr;
    ipic_pkg::vect_num_t cisv;
    logic                soi_wr;
    logic                eoi_wr;

    //------------------------------------------------------------
    // Blocks
    //------------------------------------------------------------
    ipic_line_detect u_line_detect (
        .clk(clk), .rst_n(rst_n), .irq_lines(irq_lines), .line_cfg(line_cfg),
        .sw_clr(sw_clr), .soi_clr(soi_clr), .ipr(ipr)
    );

    ipic_service u_service (
        .clk(clk), .rst_n(rst_n), .ipr(ipr), .ier(ier), .soi_wr(soi_wr),
        .eoi_wr(eoi_wr), .irq_req(irq_req), .soi_clr(soi_clr), .isvr(isvr),
        .cisv(cisv)
    );

    ipic_csr u_csr (
        .clk(clk), .rst_n(rst_n), .csr_req(csr_req), .ipr(ipr), .isvr(isvr),
        .cisv(cisv), .csr_rdata(csr_rdata), .line_cfg(line_cfg), .ier(ier),
        .sw_clr(sw_clr), .soi_wr(soi_wr), .eoi_wr(eoi_wr)
    );

endmodule

`default_nettype wire

// ==== test/ipic_assert.sv ====
/*
 * Concurrent checks on the controller top level, attached by bind.
 */

`timescale 1ns/1ps
`default_nettype none

module ipic_assert (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire ipic_pkg::vect_num_t cisv,
    input wire logic                irq_req,
    input wire ipic_pkg::csr_req_t  csr_req,
    input wire ipic_pkg::csr_data_t csr_rdata
);

    int fail_cnt = 0;  // Failed assertion count

    // Line 0 in service blocks every request
    a_no_req_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (cisv == '0) |-> !irq_req)
        else begin
            $error("request raised while line 0 in service");
            fail_cnt++;
        end

    a_cisv_range: assert property (@(posedge clk) disable iff (!rst_n)
        cisv <= ipic_pkg::VOID_VECT)
        else begin
            $error("current vector out of range");
            fail_cnt++;
        end

    a_idle_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        !csr_req.rd |-> (csr_rdata == '0))
        else begin
            $error("read data nonzero without read");
            fail_cnt++;
        end

endmodule

bind ipic_top ipic_assert u_assert (
    .clk(clk), .rst_n(rst_n), .cisv(cisv), .irq_req(irq_req),
    .csr_req(csr_req), .csr_rdata(csr_rdata)
);

`default_nettype wire

// ==== test/tb_ipic_model.svh ====
/*
 * Reference model of the controller registers and the service stack.
 * Included inside the testbench module; stepped once per rising edge.
 */

ipic_pkg::irq_vec_t  m_ipr, m_ier, m_imr, m_inv, m_isvr, m_prev;
ipic_pkg::line_idx_t m_idx;
ipic_pkg::vect_num_t m_cisv;

// Lowest requested line, -1 when none
function automatic int model_winner();
    for (int i = 0; i < ipic_pkg::IRQ_NUM; i++) begin
        if (m_ipr[i] && m_ier[i]) return i;
    end
    return -1;
endfunction

function automatic logic model_irq_req();
    int w;
    w = model_winner();
    return (w >= 0) && ((m_cisv == ipic_pkg::VOID_VECT) || (w < int'(m_cisv)));
endfunction

function automatic ipic_pkg::csr_data_t model_read(ipic_pkg::csr_req_t r);
    ipic_pkg::csr_data_t d;
    d = '0;
    if (!r.rd) return d;
    case (r.addr)
        ipic_pkg::ADDR_CISV: d = 32'(m_cisv);
        ipic_pkg::ADDR_IPR:  d = 32'(m_ipr);
        ipic_pkg::ADDR_ISVR: d = 32'(m_isvr);
        ipic_pkg::ADDR_IDX:  d = 32'(m_idx);
        ipic_pkg::ADDR_ICSR: begin
            d[0] = m_ipr[m_idx];
            d[1] = m_ier[m_idx];
            d[2] = m_imr[m_idx];
            d[3] = m_inv[m_idx];
            d[4] = m_isvr[m_idx];
            d[15:12] = m_idx;   // Line number field
        end
        default: d = '0;
    endcase
    return d;
endfunction

task automatic model_reset();
    {m_ipr, m_ier, m_imr, m_inv, m_isvr, m_prev} = '0;
    m_idx  = '0;
    m_cisv = ipic_pkg::VOID_VECT;
endtask

// ==== test/tb_ipic.sv ====
/*
 * Interrupt controller testbench with directed phases and a long random mix,
 * compared cycle by cycle with the included model.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ipic;

    logic                clk;
    logic                rst_n;
    ipic_pkg::irq_vec_t  irq_lines;
    ipic_pkg::csr_req_t  csr_req;
    ipic_pkg::csr_data_t csr_rdata;
    logic                irq_req;

    integer              seed = 32'h9002;
    ipic_pkg::irq_vec_t  cur_lines;
    logic                req_seen;    // irq_req sampled mid-cycle
    ipic_pkg::csr_data_t rdata_seen;

    `include "tb_ipic_model.svh"

    ipic_top u_dut (
        .clk(clk), .rst_n(rst_n), .irq_lines(irq_lines), .csr_req(csr_req),
        .csr_rdata(csr_rdata), .irq_req(irq_req)
    );

    always #2 clk = ~clk;  // 4 ns period

    // Model state update for one rising edge
    task automatic model_step(input ipic_pkg::irq_vec_t lines, input ipic_pkg::csr_req_t r);
        ipic_pkg::irq_vec_t nxt_ier, nxt_im, nxt_inv, clr, lvl, edg, soi_clr, rest;
        logic wr_icsr, acc;
        int w;
        wr_icsr = r.wr && (r.addr == ipic_pkg::ADDR_ICSR);
        nxt_ier = m_ier;
        nxt_im  = m_imr;
        nxt_inv = m_inv;
        if (wr_icsr) begin
            nxt_ier[m_idx] = r.wdata[1];
            nxt_im[m_idx]  = r.wdata[2];
            nxt_inv[m_idx] = r.wdata[3];
        end
        clr = '0;
        if (r.wr && r.addr == ipic_pkg::ADDR_IPR) clr = r.wdata[15:0];
        else if (wr_icsr) clr[m_idx] = r.wdata[0];
        w       = model_winner();
        acc     = r.wr && (r.addr == ipic_pkg::ADDR_SOI) && model_irq_req();
        soi_clr = '0;
        if (acc) soi_clr[w] = 1'b1;
        clr = clr | soi_clr;
        lvl = lines ^ nxt_inv;
        edg = (m_prev ^ lines) & lvl;
        for (int i = 0; i < ipic_pkg::IRQ_NUM; i++) begin
            if (clr[i] && !(lvl[i] && !nxt_im[i])) m_ipr[i] = 1'b0;  // Active level wins
            else if (nxt_im[i])                    m_ipr[i] = m_ipr[i] | edg[i];
            else                                   m_ipr[i] = lvl[i];
        end
        // Service stack
        if (acc) begin
            m_isvr = m_isvr | soi_clr;
            m_cisv = ipic_pkg::vect_num_t'(w);
        end else if (r.wr && r.addr == ipic_pkg::ADDR_EOI && m_cisv != ipic_pkg::VOID_VECT) begin
            rest = m_isvr;
            rest[m_cisv[3:0]] = 1'b0;
            m_isvr = rest;
            m_cisv = ipic_pkg::VOID_VECT;
            for (int i = ipic_pkg::IRQ_NUM - 1; i >= 0; i--) begin
                if (rest[i]) m_cisv = ipic_pkg::vect_num_t'(i);  // Lowest survives
            end
        end
        if (r.wr && r.addr == ipic_pkg::ADDR_IDX) m_idx = r.wdata[3:0];
        m_ier  = nxt_ier;
        m_imr  = nxt_im;
        m_inv  = nxt_inv;
        m_prev = lines;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic ipic_pkg::csr_req_t wr_req(ipic_pkg::csr_addr_t a, logic [31:0] d);
        return '{rd: 1'b0, wr: 1'b1, addr: a, wdata: d};
    endfunction

    function automatic ipic_pkg::csr_req_t rd_req(ipic_pkg::csr_addr_t a);
        return '{rd: 1'b1, wr: 1'b0, addr: a, wdata: '0};
    endfunction

    // One bus cycle with checks before the rising edge
    task automatic cycle(input ipic_pkg::csr_req_t r);
        @(negedge clk);
        irq_lines = cur_lines;
        csr_req   = r;
        #1;
        req_seen   = irq_req;
        rdata_seen = csr_rdata;
        check_val("csr_rdata", csr_rdata, model_read(r));
        check_val("irq_req", 32'(irq_req), 32'(model_irq_req()));
        @(posedge clk);
        model_step(cur_lines, r);
    endtask

    task automatic set_line(input int n, input logic [3:0] flags);
        cycle(wr_req(ipic_pkg::ADDR_IDX, n));
        cycle(wr_req(ipic_pkg::ADDR_ICSR, {28'd0, flags}));
    endtask

    task automatic pulse_line(input int n);
        cur_lines[n] = 1'b1;
        cycle('0);
        cur_lines[n] = 1'b0;
        cycle('0);
    endtask

    task automatic wait_for_req();
        int n;
        n = 0;
        while (!req_seen && n < 20) begin
            cycle('0);
            n++;
        end
        if (!req_seen) begin
            $display("Timeout: interrupt request never raised");
            $display("SIMULATION FAILED");
            $fatal(1, "wait for request timed out");
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        irq_lines = '0;
        csr_req = '0;
        cur_lines = '0;
        req_seen = 1'b0;
        model_reset();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        //------------------------------------------------------------
        // Level lines with random enable and inversion
        //------------------------------------------------------------
        for (int i = 0; i < 16; i++) set_line(i, 4'($random(seed)) & 4'b1010);
        repeat (40) begin
            cur_lines = 16'($random(seed));
            cycle(rd_req(ipic_pkg::ADDR_IPR));
        end

        // Edge lines, then software clear
        for (int i = 0; i < 16; i++) set_line(i, (4'($random(seed)) & 4'b1000) | 4'b0100);
        repeat (30) begin
            cur_lines = 16'($random(seed));
            cycle(rd_req(ipic_pkg::ADDR_IPR));
        end
        cycle(wr_req(ipic_pkg::ADDR_IPR, 32'hffff));
        cycle(rd_req(ipic_pkg::ADDR_IPR));
        // Active level line ignores a clear
        cur_lines = '0;
        set_line(5, 4'b0000);
        cur_lines[5] = 1'b1;
        cycle('0);
        cycle(wr_req(ipic_pkg::ADDR_IPR, 32'h20));
        cycle(rd_req(ipic_pkg::ADDR_IPR));
        check_val("ipr[5]", 32'(rdata_seen[5]), 32'd1);

        // ICSR through IDX
        repeat (40) begin
            cycle(wr_req(ipic_pkg::ADDR_IDX, $random(seed)));
            cycle(wr_req(ipic_pkg::ADDR_ICSR, $random(seed)));
            cycle(rd_req(ipic_pkg::ADDR_ICSR));
        end

        //------------------------------------------------------------
        // Nesting and EOI unwind
        //------------------------------------------------------------
        cur_lines = '0;
        for (int i = 0; i < 16; i++) set_line(i, 4'b0110);  // Edge mode and enabled
        cycle(wr_req(ipic_pkg::ADDR_IPR, 32'hffff));
        pulse_line(9);
        wait_for_req();
        cycle(wr_req(ipic_pkg::ADDR_SOI, 0));
        cycle(rd_req(ipic_pkg::ADDR_CISV));
        check_val("cisv", rdata_seen, 32'd9);
        pulse_line(12);
        cycle(rd_req(ipic_pkg::ADDR_ISVR));
        check_val("irq_req", 32'(req_seen), 32'd0);  // Higher number does not preempt
        pulse_line(4);
        wait_for_req();
        cycle(wr_req(ipic_pkg::ADDR_SOI, 0));
        pulse_line(2);
        wait_for_req();
        cycle(wr_req(ipic_pkg::ADDR_SOI, 0));
        for (int k = 0; k < 3; k++) begin
            cycle(wr_req(ipic_pkg::ADDR_EOI, 0));
            cycle(rd_req(ipic_pkg::ADDR_CISV));
            check_val("cisv unwind", rdata_seen, (k == 0) ? 32'd4 : (k == 1) ? 32'd9 : 32'd16);
        end
        cycle(wr_req(ipic_pkg::ADDR_EOI, 0));  // EOI while void is ignored
        cycle(rd_req(ipic_pkg::ADDR_CISV));
        check_val("cisv", rdata_seen, 32'd16);

        // Random mix
        repeat (3000) begin
            cur_lines = 16'($random(seed));
            cycle('{rd: 1'($random(seed)), wr: 1'($random(seed)),
                    addr: 3'($random(seed)), wdata: $random(seed)});
        end

        @(negedge clk);
        if (u_dut.u_assert.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+test
src/ipic_pkg.sv
src/ipic_line_detect.sv
src/ipic_prio_search.sv
src/ipic_service.sv
src/ipic_csr.sv
src/ipic_top.sv
test/ipic_assert.sv
test/tb_ipic.sv

// ==== Bender.yml ====
package:
  name: ipic

sources:
  - files:
      - src/ipic_pkg.sv
      - src/ipic_line_detect.sv
      - src/ipic_prio_search.sv
      - src/ipic_service.sv
      - src/ipic_csr.sv
      - src/ipic_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/ipic_assert.sv
      - test/tb_ipic.sv
